// File: seg_pkg.sv
package seg_pkg;

    localparam int num_digits     = 8;                     // Two groups of four digits
    localparam int scan_div       = 16;                    // Clk cycles per digit, sim sized
    localparam int code_w         = 8;                     // One byte per digit
    localparam int bytes_per_word = 4;
    localparam int word_w         = code_w * bytes_per_word;
    localparam int digit_idx_w    = $clog2(num_digits);
    localparam int scan_cnt_w     = $clog2(scan_div);

    // One digit's byte, 0x00..0x0F is a hex glyph, anything else blanks
    typedef logic [code_w-1:0] digit_code_t;

    // Segment bus, bit order dp g f e d c b a, active high
    typedef logic [7:0] seg_pattern_t;

    // Digit k is byte k of word0 for k < 4, byte k-4 of word1 otherwise
    typedef struct packed {
        logic [word_w-1:0] word1;                          // Digits 7..4
        logic [word_w-1:0] word0;                          // Digits 3..0
    } disp_frame_t;

    typedef struct packed {
        logic [num_digits-1:0] en;                         // One-hot digit enable
        digit_code_t           code;                       // Byte of that digit
    } scan_item_t;

    typedef struct packed {
        logic                      en;                     // Write strobe
        logic                      addr;                   // 0 selects word0, 1 word1
        logic [bytes_per_word-1:0] be;                     // Byte lane enables
        logic [word_w-1:0]         data;
    } disp_write_t;

    // Hex glyphs, dp always off
    localparam seg_pattern_t glyph_0 = 8'h3F;
    localparam seg_pattern_t glyph_1 = 8'h06;
    localparam seg_pattern_t glyph_2 = 8'h5B;
    localparam seg_pattern_t glyph_3 = 8'h4F;
    localparam seg_pattern_t glyph_4 = 8'h66;
    localparam seg_pattern_t glyph_5 = 8'h6D;
    localparam seg_pattern_t glyph_6 = 8'h7D;
    localparam seg_pattern_t glyph_7 = 8'h07;
    localparam seg_pattern_t glyph_8 = 8'h7F;
    localparam seg_pattern_t glyph_9 = 8'h6F;
    localparam seg_pattern_t glyph_a = 8'h77;
    localparam seg_pattern_t glyph_b = 8'h7C;                // Lower case b
    localparam seg_pattern_t glyph_c = 8'h39;
    localparam seg_pattern_t glyph_d = 8'h5E;                // Lower case d
    localparam seg_pattern_t glyph_e = 8'h79;
    localparam seg_pattern_t glyph_f = 8'h71;

    localparam seg_pattern_t blank_pattern = 8'h00;        // All segments off

endpackage

// File: seg_regs.sv
module seg_regs
    import seg_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  disp_write_t wr,
    output disp_frame_t frame
);

    logic [word_w-1:0] word_sel;                           // Word being written
    logic [word_w-1:0] word_next;                          // Word after lane merge

    // Replace only the byte lanes whose enable is set
    function automatic logic [word_w-1:0] merge_lanes(
        input logic [word_w-1:0]         old_word,
        input logic [word_w-1:0]         new_word,
        input logic [bytes_per_word-1:0] lanes
    );
        logic [word_w-1:0] result;
        result = old_word;
        for (int b = 0; b < bytes_per_word; b++) begin
            if (lanes[b]) begin
                result[b*code_w +: code_w] = new_word[b*code_w +: code_w];
            end
        end
        return result;
    endfunction

    assign word_sel  = wr.addr ? frame.word1 : frame.word0;
    assign word_next = merge_lanes(word_sel, wr.data, wr.be);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            frame <= '0;                                   // Display starts blank of data
        end else if (wr.en) begin
            if (wr.addr) begin
                frame.word1 <= word_next;
            end else begin
                frame.word0 <= word_next;
            end
        end
    end

    // A write with no lanes enabled is a bus error upstream
    a_write_has_lanes: assert property (
        @(posedge clk) disable iff (!rst_n)
        wr.en |-> (wr.be != '0)
    );

endmodule

// File: seg_scanner.sv
module seg_scanner
    import seg_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  disp_frame_t frame,
    output scan_item_t  item
);

    logic [scan_cnt_w-1:0]        pre_cnt;                 // Divider in place of a slow clock
    logic                         tick;                    // One cycle per scan step
    logic                         started;                 // Set by the first tick
    logic [digit_idx_w-1:0]       digit_idx;
    logic [num_digits*code_w-1:0] frame_bytes;
    logic [num_digits-1:0]        digit_en;
    digit_code_t                  digit_code;

    assign tick = (pre_cnt == scan_cnt_w'(scan_div - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pre_cnt <= '0;
        end else if (tick) begin
            pre_cnt <= '0;
        end else begin
            pre_cnt <= pre_cnt + 1'b1;
        end
    end

    // First tick only arms the scan at digit 0, later ticks advance
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            started   <= 1'b0;
            digit_idx <= '0;
        end else if (tick) begin
            started <= 1'b1;
            if (started) begin
                if (digit_idx == digit_idx_w'(num_digits - 1)) begin
                    digit_idx <= '0;                       // Wrap after digit 7
                end else begin
                    digit_idx <= digit_idx + 1'b1;
                end
            end
        end
    end

    // word0 sits in the low half, so byte k of the flat frame is digit k
    assign frame_bytes = frame;
    assign digit_code  = frame_bytes[digit_idx*code_w +: code_w];
    assign digit_en    = started ? (num_digits'(1) << digit_idx) : '0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            item <= '0;
        end else begin
            item.en   <= digit_en;                         // Loads every cycle
            item.code <= digit_code;
        end
    end

    a_item_en_onehot0: assert property (
        @(posedge clk) disable iff (!rst_n)
        $onehot0(item.en)
    );

    a_idx_moves_on_tick: assert property (
        @(posedge clk) disable iff (!rst_n)
        !tick |=> $stable(digit_idx)
    );

endmodule

// File: seg_decoder.sv
module seg_decoder
    import seg_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  scan_item_t   item,
    output logic [7:0]   seg_en,
    output seg_pattern_t seg_out0,
    output seg_pattern_t seg_out1
);

    seg_pattern_t glyph;                                   // Raw glyph of the byte
    seg_pattern_t pattern;                                 // Blanked while no digit is enabled

    always_comb begin
        case (item.code)
            8'h00:   glyph = glyph_0;
            8'h01:   glyph = glyph_1;
            8'h02:   glyph = glyph_2;
            8'h03:   glyph = glyph_3;
            8'h04:   glyph = glyph_4;
            8'h05:   glyph = glyph_5;
            8'h06:   glyph = glyph_6;
            8'h07:   glyph = glyph_7;
            8'h08:   glyph = glyph_8;
            8'h09:   glyph = glyph_9;
            8'h0A:   glyph = glyph_a;
            8'h0B:   glyph = glyph_b;
            8'h0C:   glyph = glyph_c;
            8'h0D:   glyph = glyph_d;
            8'h0E:   glyph = glyph_e;
            8'h0F:   glyph = glyph_f;
            default: glyph = blank_pattern;                // 0x10 and above
        endcase
    end

    // Before the first scan step the code is byte 0, keep the buses dark
    assign pattern = (item.en == '0) ? blank_pattern : glyph;

    // Both groups share one pattern, only the enable tells them apart
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            seg_en   <= '0;
            seg_out0 <= blank_pattern;
            seg_out1 <= blank_pattern;
        end else begin
            seg_en   <= item.en;
            seg_out0 <= pattern;
            seg_out1 <= pattern;
        end
    end

    a_buses_match: assert property (
        @(posedge clk) disable iff (!rst_n)
        seg_out0 == seg_out1
    );

endmodule

// File: seg_display_top.sv
module seg_display_top
    import seg_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  disp_write_t  wr,
    output logic [7:0]   seg_en,
    output seg_pattern_t seg_out0,
    output seg_pattern_t seg_out1
);

    disp_frame_t frame;                                    // Both display words
    scan_item_t  item;                                     // Current digit and its byte

    // Write port into the two display words
    seg_regs i_seg_regs (
        .clk   (clk),
        .rst_n (rst_n),
        .wr    (wr),
        .frame (frame)
    );

    // Steps through the eight digits
    seg_scanner i_seg_scanner (
        .clk   (clk),
        .rst_n (rst_n),
        .frame (frame),
        .item  (item)
    );

    // Byte to segments, onto both board buses
    seg_decoder i_seg_decoder (
        .clk      (clk),
        .rst_n    (rst_n),
        .item     (item),
        .seg_en   (seg_en),
        .seg_out0 (seg_out0),
        .seg_out1 (seg_out1)
    );

endmodule

// File: tb_clock_gen.sv
module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    localparam int half_period  = 20;                      // Full period of 40
    localparam int reset_cycles = 16;

    initial begin
        clk = 1'b0;
        forever begin
            #half_period clk = ~clk;
        end
    end

    // Release on a rising edge so the first scan cycle is well defined
    initial begin
        rst_n <= 1'b0;
        repeat (reset_cycles) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

// File: seg_display_tb.sv
module seg_display_tb
    import seg_pkg::*;
();

    localparam int scan_cycles     = num_digits * scan_div;   // One full pass over all digits
    localparam int first_lit_delay = scan_div + 2;            // Tick, then two register stages
    localparam int settle_cycles   = 3;                       // Write edge to visible outputs
    localparam int test_cycles     = 40 * scan_cycles;
    localparam int timeout_limit   = test_cycles + 500;

    logic         clk;
    logic         rst_n;
    disp_write_t  wr;
    logic [7:0]   seg_en;
    seg_pattern_t seg_out0;
    seg_pattern_t seg_out1;

    disp_frame_t  model_frame;                             // Expected display words
    seg_pattern_t glyph_table [16];
    int           cycle         = 0;
    int           release_cycle = 0;
    int           first_cycle   = 0;                       // Cycle where digit 0 first shows
    int           error_count   = 0;

    tb_clock_gen i_tb_clock_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    seg_display_top i_seg_display_top (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr       (wr),
        .seg_en   (seg_en),
        .seg_out0 (seg_out0),
        .seg_out1 (seg_out1)
    );

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= timeout_limit) begin
            $display("Timeout, the run did not finish within %0d cycles", timeout_limit);
            abort_run();
        end
    end

    task automatic abort_run();
        $display("ERRORS FOUND");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic check_pattern(input string name, input seg_pattern_t expected,
                                 input seg_pattern_t actual);
        if (actual !== expected) begin
            error_count++;
            $display("Fail at time %0t: %s expected %h, got %h", $time, name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_enable(input string name, input logic [7:0] expected,
                                input logic [7:0] actual);
        if (actual !== expected) begin
            error_count++;
            $display("Fail at time %0t: %s expected %b, got %b", $time, name, expected, actual);
            abort_run();
        end
    endtask

    // Digits 0..3 live in word0, 4..7 in word1
    function automatic digit_code_t model_byte(input int k);
        if (k < 4) begin
            return model_frame.word0[k*8 +: 8];
        end else begin
            return model_frame.word1[(k-4)*8 +: 8];
        end
    endfunction

    function automatic seg_pattern_t expected_glyph(input digit_code_t code);
        if (code < 8'h10) begin
            return glyph_table[code[3:0]];
        end else begin
            return 8'h00;                                  // Blank digit
        end
    endfunction

    task automatic write_word(input logic sel, input logic [3:0] lanes,
                              input logic [31:0] value);
        disp_write_t req;
        logic [31:0] mask;
        mask = '0;
        for (int lane = 0; lane < 4; lane++) begin
            if (lanes[lane]) begin
                mask[lane*8 +: 8] = 8'hFF;
            end
        end
        req.en   = 1'b1;
        req.addr = sel;
        req.be   = lanes;
        req.data = value;
        @(posedge clk);
        wr <= req;
        @(posedge clk);
        wr.en <= 1'b0;                                     // Single-cycle strobe
        if (sel) begin
            model_frame.word1 = (model_frame.word1 & ~mask) | (value & mask);
        end else begin
            model_frame.word0 = (model_frame.word0 & ~mask) | (value & mask);
        end
    endtask

    task automatic settle();
        repeat (settle_cycles) @(posedge clk);
    endtask

    // Digit shown at any cycle follows from the first lit cycle and the dwell
    task automatic check_scan(input int n_cycles);
        int           idx;
        logic [7:0]   exp_en;
        seg_pattern_t exp_seg;
        repeat (n_cycles) begin
            @(negedge clk);
            idx     = ((cycle - first_cycle) / scan_div) % num_digits;
            exp_en  = 8'(1) << idx;
            exp_seg = expected_glyph(model_byte(idx));
            check_enable("seg_en", exp_en, seg_en);
            check_pattern("seg_out0", exp_seg, seg_out0);
            check_pattern("seg_out1", exp_seg, seg_out1);
        end
    endtask

    task automatic check_dark();
        check_enable("seg_en", 8'h00, seg_en);
        check_pattern("seg_out0", 8'h00, seg_out0);
        check_pattern("seg_out1", 8'h00, seg_out1);
    endtask

    task automatic test_reset_quiet();
        do begin
            @(negedge clk);
            check_dark();
        end while (!rst_n);
        release_cycle = cycle;
        first_cycle   = release_cycle + first_lit_delay;
        while (cycle < first_cycle - 1) begin
            @(negedge clk);
            check_dark();                                  // Nothing lit before the first tick
        end
    endtask

    task automatic test_scan_order();
        check_scan(2 * scan_cycles);                       // Empty frame shows zeros everywhere
    endtask

    task automatic test_hex_decode();
        write_word(1'b0, 4'hF, 32'h0302_0100);
        write_word(1'b1, 4'hF, 32'h0706_0504);
        settle();
        check_scan(scan_cycles);
        write_word(1'b0, 4'hF, 32'h0B0A_0908);
        write_word(1'b1, 4'hF, 32'h0F0E_0D0C);
        settle();
        check_scan(scan_cycles);
    endtask

    task automatic test_blanking();
        write_word(1'b0, 4'hF, 32'h0AFF_0110);
        write_word(1'b1, 4'hF, 32'h7F0C_8003);
        settle();
        check_scan(scan_cycles);
    endtask

    task automatic test_partial_writes();
        write_word(1'b0, 4'b0001, 32'hEEEE_EE0D);          // Byte 0 only
        settle();
        check_scan(scan_cycles);
        write_word(1'b1, 4'b0100, 32'hAA06_BBCC);          // Byte 2 only
        settle();
        check_scan(scan_cycles);
        write_word(1'b0, 4'b1010, 32'h0E55_0166);
        settle();
        check_scan(scan_cycles);
        write_word(1'b1, 4'b0011, 32'h9988_0F12);
        settle();
        check_scan(scan_cycles);
    endtask

    // Rewrite the byte of the digit on display, it turns over on the third cycle
    task automatic test_write_latency();
        int           idx;
        digit_code_t  new_code;
        seg_pattern_t old_seg;
        repeat (3) begin
            do begin
                @(negedge clk);
            end while ((cycle - first_cycle) % scan_div != 4);
            idx      = ((cycle - first_cycle) / scan_div) % num_digits;
            old_seg  = expected_glyph(model_byte(idx));
            new_code = (model_byte(idx) == 8'h08) ? 8'h01 : 8'h08;
            write_word(1'(idx / 4), 4'(1) << (idx % 4), {4{new_code}});
            repeat (2) begin
                @(negedge clk);
                check_pattern("seg_out0", old_seg, seg_out0);
                check_pattern("seg_out1", old_seg, seg_out1);
            end
            check_scan(scan_cycles);                       // New glyph from here on
        end
    endtask

    task automatic test_random_frames();
        logic [3:0]  lanes;
        logic [31:0] value;
        for (int i = 0; i < 10; i++) begin
            for (int w = 0; w < 2; w++) begin
                value = $urandom;
                if (i % 2 == 0) begin
                    value = value & 32'h1F1F_1F1F;         // Half the bytes land on glyphs
                end
                lanes = 4'($urandom);
                if (lanes == 4'h0) begin
                    lanes = 4'hF;
                end
                write_word(1'(w), lanes, value);
            end
            settle();
            check_scan(scan_cycles);
        end
    endtask

    initial begin
        wr          <= '0;
        model_frame = '0;
        glyph_table = '{8'h3F, 8'h06, 8'h5B, 8'h4F, 8'h66, 8'h6D, 8'h7D, 8'h07,
                        8'h7F, 8'h6F, 8'h77, 8'h7C, 8'h39, 8'h5E, 8'h79, 8'h71};
        void'($urandom(77));
        test_reset_quiet();
        test_scan_order();
        test_hex_decode();
        test_blanking();
        test_partial_writes();
        test_write_latency();
        test_random_frames();
        if (error_count == 0) begin
            $display("NO ERRORS");
            $finish;
        end else begin
            abort_run();
        end
    end

endmodule

// File: compile.f
seg_pkg.sv
seg_regs.sv
seg_scanner.sv
seg_decoder.sv
seg_display_top.sv
tb_clock_gen.sv
seg_display_tb.sv

// File: Makefile
TOP := seg_display_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f compile.f --top-module $(TOP) -o $(TOP)

run: build
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "NO ERRORS"

lint:
	verilator --lint-only -Wall --timing -f compile.f --top-module $(TOP)

clean:
	rm -rf obj_dir
